// File: tb.f
+incdir+include
hdl/aes_pkg.sv
hdl/aes_sbox.sv
hdl/aes_round_logic.sv
hdl/aes_encipher_ctrl.sv
hdl/aes_encipher_round.sv
testbench/tb_clock.sv
testbench/aes_checker.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import aes_pkg::*;
();

  localparam int NUM_RANDOM = 20;
  // fips vector, random set, busy strobe, reset abort, op after reset
  localparam int NUM_TESTS = NUM_RANDOM + 4;
  // 60 cycles per op, slack for the reset gaps
  localparam int CYCLE_LIMIT = NUM_TESTS * 60 + 100;

  logic        clk;
  logic        por_n;
  logic        mid_reset;
  logic        reset_n;
  logic        next;
  aes_block_t  block;
  aes_block_t  key;
  aes_block_t  round_key;
  aes_round_t  round;
  aes_block_t  new_block;
  logic        ready;
  int          test_id;
  int          pass_count;
  int          fail_count;
  logic [31:0] lcg_state;
  int          cycle_count = 0;

  // power-on reset plus one forced mid-op
  assign reset_n = por_n & ~mid_reset;

  tb_clock u_clock (
    .clk     (clk),
    .reset_n (por_n)
  );

  aes_encipher_round dut0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // also returns the key for dut0's round, same cycle
  aes_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .next       (next),
    .ready      (ready),
    .new_block  (new_block),
    .round      (round),
    .key        (key),
    .block      (block),
    .test_id    (test_id),
    .round_key  (round_key),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  // ----------------------------------------------------------------------
  // stimulus, all on the falling edge
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_block(output aes_block_t value);
    for (int i = 0; i < 4; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      value[127-32*i -: 32] = lcg_state;
    end
  endtask

  // one-cycle strobe, block and key held until the next op
  task automatic start_op(input int id, input aes_block_t op_key, input aes_block_t op_block);
    @(negedge clk);
    test_id = id;
    key = op_key;
    block = op_block;
    next = 1'b1;
    @(negedge clk);
    next = 1'b0;
  endtask

  // gap lets the checker close the op before the next strobe
  task automatic wait_ready;
    while (ready !== 1'b1)
      @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  initial
  begin
    aes_block_t k;
    aes_block_t b;
    aes_block_t b2;
    lcg_state = 32'h25af;
    next = 1'b0;
    block = '0;
    key = '0;
    test_id = 0;
    mid_reset = 1'b0;
    wait (reset_n === 1'b1);
    @(negedge clk);

    // FIPS-197 appendix B
    start_op(0, 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734);
    wait_ready();

    for (int i = 1; i <= NUM_RANDOM; i++)
    begin
      draw_block(k);
      draw_block(b);
      start_op(i, k, b);
      wait_ready();
    end

    // second strobe with another block while busy
    draw_block(k);
    draw_block(b);
    draw_block(b2);
    start_op(NUM_RANDOM + 1, k, b);
    repeat (10) @(negedge clk);
    block = b2;
    next = 1'b1;
    @(negedge clk);
    next = 1'b0;
    wait_ready();

    // reset in the middle of round work
    draw_block(k);
    draw_block(b);
    start_op(NUM_RANDOM + 2, k, b);
    repeat (20) @(negedge clk);
    mid_reset = 1'b1;
    repeat (3) @(negedge clk);
    mid_reset = 1'b0;
    repeat (3) @(negedge clk);

    draw_block(k);
    draw_block(b);
    start_op(NUM_RANDOM + 3, k, b);
    wait_ready();

    $display("tests: %0d passed, %0d failed, %0d expected", pass_count, fail_count, NUM_TESTS);
    if (fail_count == 0 && pass_count == NUM_TESTS)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

endmodule

// File: testbench/aes_checker.sv
`timescale 1ns/1ps

module aes_checker
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       ready,
  input  aes_block_t new_block,
  input  aes_round_t round,
  input  aes_block_t key,
  input  aes_block_t block,
  input  int         test_id,
  output aes_block_t round_key,
  output int         pass_count,
  output int         fail_count
);

  // edges from the accepted strobe to ready high
  localparam int LATENCY = 52;

  // FIPS-197 appendix B ciphertext for test 0
  localparam aes_block_t FIPS_CT = 128'h3925841d02dc09fbdc118597196a0b32;

  // 11 round keys with key 0 in the top bits
  logic [1407:0] sched_cur;

  aes_block_t exp_block = '0;
  logic       busy = 1'b0;
  logic       aborted = 1'b0;
  logic       test_ok = 1'b1;
  int         cycles = 0;
  int         cur_id = 0;
  int         passes = 0;
  int         fails = 0;

  // ----------------------------------------------------------------------
  // reference AES-128 with bytes numbered from the top of the block
  // ----------------------------------------------------------------------

  // shift-and-add product in GF(2^8)
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // field inverse as a^254 followed by the affine map
  function automatic logic [7:0] sub_byte(input logic [7:0] a);
    logic [7:0] inv;
    inv = 8'h01;
    for (int i = 0; i < 254; i++)
      inv = gf_mul(inv, a);
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  function automatic logic [1407:0] expand_key(input logic [127:0] k);
    logic [31:0]   w [44];
    logic [31:0]   temp;
    logic [7:0]    rcon;
    logic [1407:0] sched;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++)
      w[i] = k[127-32*i -: 32];
    for (int i = 4; i < 44; i++)
    begin
      temp = w[i-1];
      if (i % 4 == 0)
      begin
        // RotWord, SubWord, round constant on the top byte
        temp = {sub_byte(temp[23:16]), sub_byte(temp[15:8]),
                sub_byte(temp[7:0]), sub_byte(temp[31:24])};
        temp[31:24] = temp[31:24] ^ rcon;
        rcon = gf_mul(rcon, 8'h02);
      end
      w[i] = w[i-4] ^ temp;
    end
    for (int i = 0; i < 44; i++)
      sched[1407-32*i -: 32] = w[i];
    return sched;
  endfunction

  function automatic logic [127:0] aes_ref(input logic [127:0] k, input logic [127:0] pt);
    logic [1407:0] sched;
    logic [7:0]    s [16];
    logic [7:0]    t [16];
    logic [127:0]  ct;
    sched = expand_key(k);
    // byte 4*c+r is row r of column c
    for (int i = 0; i < 16; i++)
      s[i] = pt[127-8*i -: 8] ^ sched[1407-8*i -: 8];
    for (int rnd = 1; rnd <= 10; rnd++)
    begin
      // SubBytes with ShiftRows where row r takes column c+r
      for (int c = 0; c < 4; c++)
        for (int r = 0; r < 4; r++)
          t[4*c+r] = sub_byte(s[4*((c+r)%4)+r]);
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          // circulant 02 03 01 01 skipped in the last round
          if (rnd == 10)
            s[4*c+r] = t[4*c+r];
          else
            s[4*c+r] = gf_mul(t[4*c+r], 8'h02) ^ gf_mul(t[4*c+(r+1)%4], 8'h03)
                     ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
          s[4*c+r] = s[4*c+r] ^ sched[1407-128*rnd-8*(4*c+r) -: 8];
        end
      end
    end
    for (int i = 0; i < 16; i++)
      ct[127-8*i -: 8] = s[i];
    return ct;
  endfunction

  // ----------------------------------------------------------------------
  // key return and result checks
  // ----------------------------------------------------------------------

  // schedule for the key under test indexed by the DUT's round
  always_comb
  begin
    sched_cur = expand_key(key);
  end

  assign round_key = sched_cur[1407 - 128*round -: 128];

  assign pass_count = passes;
  assign fail_count = fails;

  function automatic string test_name(input int id);
    if (id == 0)
      return "fips197";
    if (id <= 20)
      return $sformatf("random_%0d", id);
    if (id == 21)
      return "busy_next";
    if (id == 22)
      return "reset_abort";
    return "after_reset";
  endfunction

  task automatic value_error(input int id, input aes_block_t expected, input aes_block_t actual);
    $display("[ERROR] test %s: expected %h, actual %h", test_name(id), expected, actual);
    test_ok = 1'b0;
  endtask

  task automatic close_test(input int id);
    if (test_ok)
    begin
      passes++;
      $display("test %s: passed", test_name(id));
    end
    else
    begin
      fails++;
      $display("test %s: failed", test_name(id));
    end
  endtask

  // DUT outputs sampled on the rising edge hold values from the edge before
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      // op cut short and checked once reset is released
      if (busy)
        aborted = 1'b1;
      busy = 1'b0;
    end
    else if (aborted)
    begin
      aborted = 1'b0;
      if (ready !== 1'b1)
      begin
        $display("[ERROR] test %s: ready is not high after reset", test_name(cur_id));
        test_ok = 1'b0;
      end
      if (round !== '0)
      begin
        $display("[ERROR] test %s: round expected 0, actual %0d", test_name(cur_id), round);
        test_ok = 1'b0;
      end
      if (new_block !== '0)
        value_error(cur_id, '0, new_block);
      close_test(cur_id);
    end
    else if (busy)
    begin
      // any next seen here is a busy strobe and must be dropped
      cycles++;
      if (ready === 1'b1)
      begin
        busy = 1'b0;
        // high level seen one edge after the edge that raised it
        if (cycles != LATENCY + 1)
        begin
          $display("[ERROR] test %s: ready rose %0d cycles after next instead of %0d",
                   test_name(cur_id), cycles - 1, LATENCY);
          test_ok = 1'b0;
        end
        if (new_block !== exp_block)
          value_error(cur_id, exp_block, new_block);
        close_test(cur_id);
      end
    end
    else if (ready === 1'b1 && next === 1'b1)
    begin
      busy = 1'b1;
      cycles = 0;
      test_ok = 1'b1;
      cur_id = test_id;
      // published value for the known vector
      if (test_id == 0)
        exp_block = FIPS_CT;
      else
        exp_block = aes_ref(key, block);
    end
  end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
  output logic clk,
  output logic reset_n
);

  // 8 ns period
  initial
  begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // power-on reset, low for 5 rising edges
  // released on a falling edge like the other inputs
  initial
  begin
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// File: hdl/aes_encipher_round.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_encipher_round
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  aes_block_t block,
  input  aes_block_t round_key,
  output aes_round_t round,
  output aes_block_t new_block,
  output logic       ready
);

  // controller outputs
  aes_sword_t      sword;
  aes_round_type_t round_type;
  logic            init_block;
  logic            sbox_we;
  logic            update_block;

  // state columns, word 0 is the top of the block
  aes_word_t state_words [`AES_NUM_WORDS];
  aes_word_t word_new [`AES_NUM_WORDS];
  logic      word_we [`AES_NUM_WORDS];

  aes_block_t cur_state;
  aes_block_t logic_state;
  aes_block_t new_state;
  aes_word_t  sbox_in;
  aes_word_t  sbox_out;

  // ----------------------------------------------------------------------
  // instances
  // ----------------------------------------------------------------------
  aes_encipher_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .next         (next),
    .sword        (sword),
    .round        (round),
    .round_type   (round_type),
    .init_block   (init_block),
    .sbox_we      (sbox_we),
    .update_block (update_block),
    .ready        (ready)
  );

  aes_round_logic u_round_logic (
    .state      (logic_state),
    .round_key  (round_key),
    .round_type (round_type),
    .new_state  (new_state)
  );

  // one shared word-wide S-box, four cycles per round
  aes_sbox u_sbox (
    .in_word  (sbox_in),
    .out_word (sbox_out)
  );

  // ----------------------------------------------------------------------
  // state words
  // ----------------------------------------------------------------------
  assign cur_state = {state_words[0], state_words[1], state_words[2], state_words[3]};

  // initial round works on the incoming block
  assign logic_state = init_block ? block : cur_state;

  // SubBytes column select
  assign sbox_in = state_words[sword];

  // full-block load wins over the single-word write back
  always_comb
  begin
    for (int i = 0; i < `AES_NUM_WORDS; i++)
    begin
      word_we[i]  = 1'b0;
      word_new[i] = new_state[`AES_BLOCK_W-1-`AES_WORD_W*i -: `AES_WORD_W];
      if (init_block || update_block)
        word_we[i] = 1'b1;
      else if (sbox_we && sword == aes_sword_t'(i))
      begin
        word_we[i]  = 1'b1;
        word_new[i] = sbox_out;
      end
    end
  end

  // cleared on reset so the output reads zero until the first result
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `AES_NUM_WORDS; i++)
    begin
      if (!reset_n)
        state_words[i] <= '0;
      else if (word_we[i])
        state_words[i] <= word_new[i];
    end
  end

  // result held here until the next accepted strobe
  assign new_block = cur_state;

endmodule

// File: hdl/aes_encipher_ctrl.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_encipher_ctrl
  import aes_pkg::*;
(
  input  logic            clk,
  input  logic            reset_n,
  input  logic            next,
  output aes_sword_t      sword,
  output aes_round_t      round,
  output aes_round_type_t round_type,
  output logic            init_block,
  output logic            sbox_we,
  output logic            update_block,
  output logic            ready
);

  // last column index and last round index
  localparam aes_sword_t LAST_SWORD = aes_sword_t'(`AES_NUM_WORDS - 1);
  localparam aes_round_t LAST_ROUND = aes_round_t'(`AES_NUM_ROUNDS);

  aes_ctrl_state_t state_reg;
  aes_ctrl_state_t state_new;

  // SubBytes word counter
  aes_sword_t sword_reg;
  aes_sword_t sword_new;

  // round counter, 0 for the initial round
  aes_round_t round_reg;
  aes_round_t round_new;

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= CTRL_IDLE;
      sword_reg <= '0;
      round_reg <= '0;
    end
    else
    begin
      state_reg <= state_new;
      sword_reg <= sword_new;
      round_reg <= round_new;
    end
  end

  // ----------------------------------------------------------------------
  // sequence
  // idle -> init -> (sbox x4 -> update) x10 -> done -> idle
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_new = state_reg;
    sword_new = sword_reg;
    round_new = round_reg;
    case (state_reg)
      CTRL_IDLE:
      begin
        // strobe only taken here, ignored while busy
        if (next)
          state_new = CTRL_INIT;
      end
      CTRL_INIT:
      begin
        // block loaded this cycle, first real round next
        sword_new = '0;
        round_new = aes_round_t'(1);
        state_new = CTRL_SBOX;
      end
      CTRL_SBOX:
      begin
        // counter wraps back to 0 after the last column
        sword_new = sword_reg + 1'b1;
        if (sword_reg == LAST_SWORD)
          state_new = CTRL_UPDATE;
      end
      CTRL_UPDATE:
      begin
        if (round_reg == LAST_ROUND)
          state_new = CTRL_DONE;
        else
        begin
          round_new = round_reg + 1'b1;
          state_new = CTRL_SBOX;
        end
      end
      CTRL_DONE:
      begin
        // back to round 0 so idle shows the initial key index
        round_new = '0;
        state_new = CTRL_IDLE;
      end
      default:
      begin
        state_new = CTRL_IDLE;
      end
    endcase
  end

  // round type follows the round counter
  always_comb
  begin
    if (state_reg == CTRL_INIT || round_reg == '0)
      round_type = ROUND_INIT;
    else if (round_reg == LAST_ROUND)
      round_type = ROUND_FINAL;
    else
      round_type = ROUND_MAIN;
  end

  // strobes decoded straight from the state register
  assign init_block   = (state_reg == CTRL_INIT);
  assign sbox_we      = (state_reg == CTRL_SBOX);
  assign update_block = (state_reg == CTRL_UPDATE);
  assign ready        = (state_reg == CTRL_IDLE);

  assign sword = sword_reg;
  assign round = round_reg;

endmodule

// File: hdl/aes_round_logic.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_round_logic
  import aes_pkg::*;
(
  input  aes_block_t      state,
  input  aes_block_t      round_key,
  input  aes_round_type_t round_type,
  output aes_block_t      new_state
);

  // ----------------------------------------------------------------------
  // GF(2^8) helpers for MixColumns
  // ----------------------------------------------------------------------

  // multiply by x, reduce by the AES polynomial
  function automatic aes_byte_t gm2(input aes_byte_t op);
    gm2 = {op[`AES_BYTE_W-2:0], 1'b0} ^ (8'h1b & {`AES_BYTE_W{op[`AES_BYTE_W-1]}});
  endfunction

  // multiply by x+1
  function automatic aes_byte_t gm3(input aes_byte_t op);
    gm3 = gm2(op) ^ op;
  endfunction

  // one column through the MixColumns matrix
  // row 3 uses b2 from the input column, not the mixed one
  function automatic aes_word_t mix_column(input aes_word_t col);
    aes_byte_t b0;
    aes_byte_t b1;
    aes_byte_t b2;
    aes_byte_t b3;
    b0 = col[31:24];
    b1 = col[23:16];
    b2 = col[15:8];
    b3 = col[7:0];
    mix_column[31:24] = gm2(b0) ^ gm3(b1) ^ b2      ^ b3;
    mix_column[23:16] = b0      ^ gm2(b1) ^ gm3(b2) ^ b3;
    mix_column[15:8]  = b0      ^ b1      ^ gm2(b2) ^ gm3(b3);
    mix_column[7:0]   = gm3(b0) ^ b1      ^ b2      ^ gm2(b3);
  endfunction

  // ----------------------------------------------------------------------
  // round chain
  // ----------------------------------------------------------------------

  // after ShiftRows
  aes_block_t shifted_state;
  // after MixColumns
  aes_block_t mixed_state;

  // ShiftRows
  // row r of column c comes from column c+r
  always_comb
  begin
    for (int c = 0; c < `AES_NUM_WORDS; c++)
    begin
      for (int r = 0; r < `AES_NUM_WORDS; r++)
      begin
        shifted_state[`AES_BLOCK_W-1-`AES_WORD_W*c-`AES_BYTE_W*r -: `AES_BYTE_W] =
          state[`AES_BLOCK_W-1-`AES_WORD_W*((c+r)%`AES_NUM_WORDS)-`AES_BYTE_W*r
                -: `AES_BYTE_W];
      end
    end
  end

  // MixColumns, column by column
  always_comb
  begin
    for (int c = 0; c < `AES_NUM_WORDS; c++)
    begin
      mixed_state[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W] =
        mix_column(shifted_state[`AES_BLOCK_W-1-`AES_WORD_W*c -: `AES_WORD_W]);
    end
  end

  // AddRoundKey on whichever stage the round type picks
  // init: block in, no SubBytes stage at all
  // final: no MixColumns
  always_comb
  begin
    case (round_type)
      ROUND_INIT:
      begin
        new_state = state ^ round_key;
      end
      ROUND_MAIN:
      begin
        new_state = mixed_state ^ round_key;
      end
      ROUND_FINAL:
      begin
        new_state = shifted_state ^ round_key;
      end
      default:
      begin
        new_state = '0;
      end
    endcase
  end

endmodule

// File: hdl/aes_sbox.sv
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes_sbox
  import aes_pkg::*;
(
  input  aes_word_t in_word,
  output aes_word_t out_word
);

  // forward S-box, FIPS-197 figure 7
  // indexed by the full input byte
  localparam aes_byte_t sbox_table [0:255] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // four lookups side by side, one per row byte
  always_comb
  begin
    for (int i = 0; i < `AES_WORD_W / `AES_BYTE_W; i++)
    begin
      out_word[`AES_WORD_W-1-`AES_BYTE_W*i -: `AES_BYTE_W] =
        sbox_table[in_word[`AES_WORD_W-1-`AES_BYTE_W*i -: `AES_BYTE_W]];
    end
  end

endmodule

// File: hdl/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

  // ----------------------------------------------------------------------
  // datapath vectors
  // ----------------------------------------------------------------------

  // block or round key, column 0 in the top bits
  typedef logic [`AES_BLOCK_W-1:0] aes_block_t;

  // one column, byte 0 (row 0) in the top bits
  typedef logic [`AES_WORD_W-1:0] aes_word_t;

  typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

  // ----------------------------------------------------------------------
  // control indices
  // ----------------------------------------------------------------------

  // round index 0..10, 0 is the initial round
  typedef logic [$clog2(`AES_NUM_ROUNDS + 1)-1:0] aes_round_t;

  // column that SubBytes is working on
  typedef logic [$clog2(`AES_NUM_WORDS)-1:0] aes_sword_t;

  // update selected in the round logic
  typedef enum logic [1:0] {
    ROUND_INIT,
    ROUND_MAIN,
    ROUND_FINAL
  } aes_round_type_t;

  // controller states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_SBOX,
    CTRL_UPDATE,
    CTRL_DONE
  } aes_ctrl_state_t;

endpackage

// File: include/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// ----------------------------------------------------------------------
// AES-128 sizes
// ----------------------------------------------------------------------

// full block, also the width of one round key
`define AES_BLOCK_W 128

// one state column
`define AES_WORD_W 32

// one state byte
`define AES_BYTE_W 8

// ----------------------------------------------------------------------
// round structure
// ----------------------------------------------------------------------

// rounds after the initial AddRoundKey
// the last one of these skips MixColumns
`define AES_NUM_ROUNDS 10

// columns per block
// also the number of SubBytes cycles per round
`define AES_NUM_WORDS 4

`endif
